// ==== id_pkg.sv ====
`default_nettype none

package id_pkg;

    localparam int XLEN     = 64;
    localparam int ILEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             xlen_t;
    typedef logic [ILEN-1:0]             inst_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // base opcodes, inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_sel_e;
    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE,
        BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_type_e;

    // encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DWORD} mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      word_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        br_type_e  br_type;
        logic      rf_re1;
        logic      rf_re2;
        logic      rf_we;
        reg_addr_t rd;
        logic      mem_ena;
        logic      mem_wen;
        mem_size_e mem_size;
        logic      mem_unsigned;
        logic      load;
        logic      ebreak;
        logic      illegal;
    } ctrl_t;

    // one later stage's pending register write
    typedef struct packed {
        logic      we;
        logic      load;
        reg_addr_t waddr;
        xlen_t     data;
    } byp_t;

endpackage

`default_nettype wire

// ==== id_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_regfile (
    input  wire               clk,
    input  wire               arst_n_i,
    input  wire               we_i,
    input  id_pkg::reg_addr_t waddr_i,
    input  id_pkg::xlen_t     wdata_i,
    input  id_pkg::reg_addr_t raddr1_i,
    input  id_pkg::reg_addr_t raddr2_i,
    output id_pkg::xlen_t     rdata1_o,
    output id_pkg::xlen_t     rdata2_o
);

    // storage for x1..x31 only
    id_pkg::xlen_t regs_q [1:id_pkg::NUM_REGS-1];

    for (genvar i = 1; i < id_pkg::NUM_REGS; i++) begin : g_reg
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                regs_q[i] <= '0;
            end else if (we_i && waddr_i == id_pkg::reg_addr_t'(i)) begin
                regs_q[i] <= wdata_i;
            end
        end

        // a write to x0 lands in no register
        a_x0_write_dropped: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            (we_i && waddr_i == '0) |=> $stable(regs_q[i])
        );
    end

    // asynchronous reads
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

// ==== id_operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_operand_fetch (
    input  wire               clk,
    input  wire               arst_n_i,
    input  id_pkg::reg_addr_t rs1_i,
    input  id_pkg::reg_addr_t rs2_i,
    input  wire               re1_i,
    input  wire               re2_i,
    input  id_pkg::byp_t      ex_byp_i,
    input  id_pkg::byp_t      mem_byp_i,
    input  id_pkg::byp_t      wb_byp_i,
    output id_pkg::xlen_t     rdata1_o,
    output id_pkg::xlen_t     rdata2_o,
    output logic              stall_o
);

    id_pkg::xlen_t rf_port1;
    id_pkg::xlen_t rf_port2;
    logic          stall1;
    logic          stall2;

    function automatic logic byp_hit(input id_pkg::byp_t byp, input id_pkg::reg_addr_t idx);
        return byp.we && (byp.waddr == idx) && (idx != '0);
    endfunction

    // priority is ex, mem, wb, then the regfile
    // a load in ex or mem has no data yet
    function automatic id_pkg::xlen_t byp_select(
        input id_pkg::reg_addr_t idx,
        input id_pkg::byp_t      ex,
        input id_pkg::byp_t      mem,
        input id_pkg::byp_t      wb,
        input id_pkg::xlen_t     rf_data
    );
        if (byp_hit(ex, idx) && !ex.load) begin
            return ex.data;
        end else if (byp_hit(mem, idx) && !mem.load) begin
            return mem.data;
        end else if (byp_hit(wb, idx)) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    function automatic logic load_use(
        input id_pkg::reg_addr_t idx,
        input id_pkg::byp_t      ex,
        input id_pkg::byp_t      mem
    );
        return (byp_hit(ex, idx) && ex.load) || (byp_hit(mem, idx) && mem.load);
    endfunction

    // wb stage owns the write port
    id_regfile u_regfile (
        .clk      (clk           ),
        .arst_n_i (arst_n_i      ),
        .we_i     (wb_byp_i.we   ),
        .waddr_i  (wb_byp_i.waddr),
        .wdata_i  (wb_byp_i.data ),
        .raddr1_i (rs1_i         ),
        .raddr2_i (rs2_i         ),
        .rdata1_o (rf_port1      ),
        .rdata2_o (rf_port2      )
    );

    assign rdata1_o = byp_select(rs1_i, ex_byp_i, mem_byp_i, wb_byp_i, rf_port1);
    assign rdata2_o = byp_select(rs2_i, ex_byp_i, mem_byp_i, wb_byp_i, rf_port2);

    // only sources that are actually read can stall
    assign stall1  = re1_i && load_use(rs1_i, ex_byp_i, mem_byp_i);
    assign stall2  = re2_i && load_use(rs2_i, ex_byp_i, mem_byp_i);
    assign stall_o = stall1 || stall2;

    // a stall needs a used nonzero source
    a_stall_needs_read: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        stall_o |-> ((re1_i && rs1_i != '0) || (re2_i && rs2_i != '0))
    );

endmodule

`default_nettype wire

// ==== id_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
    input  id_pkg::inst_t     inst_i,
    output id_pkg::ctrl_t     ctrl_o,
    output id_pkg::xlen_t     imm_o,
    output id_pkg::reg_addr_t rs1_o,
    output id_pkg::reg_addr_t rs2_o
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    id_pkg::xlen_t imm_i;
    id_pkg::xlen_t imm_s;
    id_pkg::xlen_t imm_b;
    id_pkg::xlen_t imm_u;
    id_pkg::xlen_t imm_j;
    id_pkg::ctrl_t ctrl;
    logic          legal;

    function automatic id_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
            3'b001:  return id_pkg::ALU_SLL;
            3'b010:  return id_pkg::ALU_SLT;
            3'b011:  return id_pkg::ALU_SLTU;
            3'b100:  return id_pkg::ALU_XOR;
            3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            3'b110:  return id_pkg::ALU_OR;
            default: return id_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            id_pkg::OP_LUI, id_pkg::OP_AUIPC: imm_o = imm_u;
            id_pkg::OP_JAL:                   imm_o = imm_j;
            id_pkg::OP_BRANCH:                imm_o = imm_b;
            id_pkg::OP_STORE:                 imm_o = imm_s;
            id_pkg::OP_JALR, id_pkg::OP_LOAD, id_pkg::OP_IMM,
            id_pkg::OP_IMM32, id_pkg::OP_SYSTEM: imm_o = imm_i;
            default:                          imm_o = '0;
        endcase
    end

    always_comb begin
        ctrl    = '0;
        ctrl.rd = inst_i[11:7];
        legal   = 1'b1;
        case (opcode)
            id_pkg::OP_LUI, id_pkg::OP_AUIPC: begin
                ctrl.src1_sel = (opcode == id_pkg::OP_LUI) ? id_pkg::SRC1_ZERO
                                                           : id_pkg::SRC1_PC;
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rf_we    = 1'b1;
            end
            id_pkg::OP_JAL, id_pkg::OP_JALR: begin
                // link value pc + 4 goes through the ALU
                ctrl.src1_sel = id_pkg::SRC1_PC;
                ctrl.src2_sel = id_pkg::SRC2_FOUR;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_re1   = (opcode == id_pkg::OP_JALR);
                ctrl.br_type  = (opcode == id_pkg::OP_JAL) ? id_pkg::BR_JAL : id_pkg::BR_JALR;
                legal         = (opcode == id_pkg::OP_JAL) || (funct3 == 3'b000);
            end
            id_pkg::OP_BRANCH: begin
                ctrl.rf_re1 = 1'b1;
                ctrl.rf_re2 = 1'b1;
                ctrl.alu_op = id_pkg::ALU_SUB;
                case (funct3)
                    3'b000:  ctrl.br_type = id_pkg::BR_BEQ;
                    3'b001:  ctrl.br_type = id_pkg::BR_BNE;
                    3'b100:  ctrl.br_type = id_pkg::BR_BLT;
                    3'b101:  ctrl.br_type = id_pkg::BR_BGE;
                    3'b110:  ctrl.br_type = id_pkg::BR_BLTU;
                    3'b111:  ctrl.br_type = id_pkg::BR_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            id_pkg::OP_LOAD, id_pkg::OP_STORE: begin
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rf_re1   = 1'b1;
                ctrl.mem_ena  = 1'b1;
                ctrl.mem_size = id_pkg::mem_size_e'(funct3[1:0]);
                if (opcode == id_pkg::OP_LOAD) begin
                    ctrl.rf_we        = 1'b1;
                    ctrl.load         = 1'b1;
                    ctrl.mem_unsigned = funct3[2];
                    legal             = (funct3 != 3'b111);
                end else begin
                    ctrl.rf_re2  = 1'b1;
                    ctrl.mem_wen = 1'b1;
                    legal        = !funct3[2];
                end
            end
            id_pkg::OP_IMM, id_pkg::OP_IMM32: begin
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rf_re1   = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.word_op  = (opcode == id_pkg::OP_IMM32);
                ctrl.alu_op   = f3_to_alu(funct3, (funct3 == 3'b101) && inst_i[30]);
                // shamt is 6 bits wide and 5 in the word forms
                if (funct3 == 3'b001) begin
                    legal = ctrl_word_ok(ctrl.word_op, funct7) && !inst_i[30];
                end else if (funct3 == 3'b101) begin
                    legal = ctrl_word_ok(ctrl.word_op, funct7);
                end else if (ctrl.word_op) begin
                    legal = (funct3 == 3'b000);
                end
            end
            id_pkg::OP_REG, id_pkg::OP_REG32: begin
                ctrl.rf_re1  = 1'b1;
                ctrl.rf_re2  = 1'b1;
                ctrl.rf_we   = 1'b1;
                ctrl.word_op = (opcode == id_pkg::OP_REG32);
                ctrl.alu_op  = f3_to_alu(funct3, funct7[5]);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                if (ctrl.word_op && funct3 != 3'b000 && funct3 != 3'b001 &&
                    funct3 != 3'b101) begin
                    legal = 1'b0;
                end
            end
            id_pkg::OP_SYSTEM: begin
                // ebreak only
                legal       = (inst_i == 32'h0010_0073);
                ctrl.ebreak = legal;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

    // upper shift bits form funct6 in 64-bit forms and funct7 in word forms
    function automatic logic ctrl_word_ok(input logic word, input logic [6:0] f7);
        if (word) begin
            return (f7[6] == 1'b0) && (f7[4:0] == 5'b0);
        end
        return (f7[6] == 1'b0) && (f7[4:1] == 4'b0);
    endfunction

    assign ctrl_o = ctrl;

endmodule

`default_nettype wire

// ==== id_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit (
    input  id_pkg::xlen_t pc_i,
    input  id_pkg::xlen_t rdata1_i,
    input  id_pkg::xlen_t rdata2_i,
    input  id_pkg::xlen_t imm_i,
    input  id_pkg::ctrl_t ctrl_i,
    output logic          branch_o,
    output id_pkg::xlen_t branch_pc_o,
    output id_pkg::xlen_t alu_src1_o,
    output id_pkg::xlen_t alu_src2_o
);

    id_pkg::xlen_t diff;
    logic          carry;
    logic          eq;
    logic          lt;
    logic          ltu;
    id_pkg::xlen_t jalr_pc;
    id_pkg::xlen_t pc_rel;

    // rdata1 - rdata2 as rdata1 + ~rdata2 + 1, carry out means no borrow
    assign {carry, diff} = {1'b0, rdata1_i} + {1'b0, ~rdata2_i} + 65'd1;
    assign eq  = (diff == '0);
    assign ltu = !carry;
    assign lt  = (rdata1_i[63] && !rdata2_i[63]) ||
                 ((rdata1_i[63] == rdata2_i[63]) && diff[63]);

    always_comb begin
        case (ctrl_i.br_type)
            id_pkg::BR_JAL,
            id_pkg::BR_JALR: branch_o = 1'b1;
            id_pkg::BR_BEQ:  branch_o = eq;
            id_pkg::BR_BNE:  branch_o = !eq;
            id_pkg::BR_BLT:  branch_o = lt;
            id_pkg::BR_BGE:  branch_o = !lt;
            id_pkg::BR_BLTU: branch_o = ltu;
            id_pkg::BR_BGEU: branch_o = !ltu;
            default:         branch_o = 1'b0;
        endcase
    end

    assign jalr_pc = (rdata1_i + imm_i) & ~id_pkg::xlen_t'(1);
    assign pc_rel  = pc_i + imm_i;

    // zero target when nothing is taken
    always_comb begin
        if (!branch_o) begin
            branch_pc_o = '0;
        end else if (ctrl_i.br_type == id_pkg::BR_JALR) begin
            branch_pc_o = jalr_pc;
        end else begin
            branch_pc_o = pc_rel;
        end
    end

    always_comb begin
        case (ctrl_i.src1_sel)
            id_pkg::SRC1_PC:   alu_src1_o = pc_i;
            id_pkg::SRC1_ZERO: alu_src1_o = '0;
            default:           alu_src1_o = rdata1_i;
        endcase
    end

    always_comb begin
        case (ctrl_i.src2_sel)
            id_pkg::SRC2_IMM:  alu_src2_o = imm_i;
            id_pkg::SRC2_FOUR: alu_src2_o = id_pkg::xlen_t'(4);
            default:           alu_src2_o = rdata2_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire           clk,
    input  wire           arst_n_i,
    input  id_pkg::xlen_t pc_i,
    input  id_pkg::inst_t inst_i,
    input  id_pkg::byp_t  ex_byp_i,
    input  id_pkg::byp_t  mem_byp_i,
    input  id_pkg::byp_t  wb_byp_i,
    output id_pkg::ctrl_t ctrl_o,
    output id_pkg::xlen_t alu_src1_o,
    output id_pkg::xlen_t alu_src2_o,
    output id_pkg::xlen_t store_data_o,
    output logic          branch_o,
    output id_pkg::xlen_t branch_pc_o,
    output logic          stall_o
);

    id_pkg::ctrl_t     ctrl;
    id_pkg::xlen_t     imm;
    id_pkg::reg_addr_t rs1;
    id_pkg::reg_addr_t rs2;
    id_pkg::xlen_t     rdata1;
    id_pkg::xlen_t     rdata2;

    id_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl  ),
        .imm_o  (imm   ),
        .rs1_o  (rs1   ),
        .rs2_o  (rs2   )
    );

    id_operand_fetch u_operand_fetch (
        .clk       (clk        ),
        .arst_n_i  (arst_n_i   ),
        .rs1_i     (rs1        ),
        .rs2_i     (rs2        ),
        .re1_i     (ctrl.rf_re1),
        .re2_i     (ctrl.rf_re2),
        .ex_byp_i  (ex_byp_i   ),
        .mem_byp_i (mem_byp_i  ),
        .wb_byp_i  (wb_byp_i   ),
        .rdata1_o  (rdata1     ),
        .rdata2_o  (rdata2     ),
        .stall_o   (stall_o    )
    );

    id_branch_unit u_branch_unit (
        .pc_i        (pc_i       ),
        .rdata1_i    (rdata1     ),
        .rdata2_i    (rdata2     ),
        .imm_i       (imm        ),
        .ctrl_i      (ctrl       ),
        .branch_o    (branch_o   ),
        .branch_pc_o (branch_pc_o),
        .alu_src1_o  (alu_src1_o ),
        .alu_src2_o  (alu_src2_o )
    );

    assign ctrl_o       = ctrl;
    assign store_data_o = rdata2;

    // illegal words must be inert across decode, fetch and branch logic
    a_illegal_inert: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ctrl.illegal |-> !(branch_o || stall_o || ctrl.rf_we || ctrl.mem_ena)
    );

endmodule

`default_nettype wire

// ==== id_tb_model.svh ====
`ifndef ID_TB_MODEL_SVH
`define ID_TB_MODEL_SVH

// reference model of the decode stage, evaluated from the RV64I field rules

function automatic id_pkg::xlen_t model_imm(input id_pkg::inst_t w);
    logic [6:0] op;
    op = w[6:0];
    if (op == id_pkg::OP_LUI || op == id_pkg::OP_AUIPC) begin
        return {{32{w[31]}}, w[31:12], 12'h000};
    end else if (op == id_pkg::OP_JAL) begin
        return {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end else if (op == id_pkg::OP_BRANCH) begin
        return {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end else if (op == id_pkg::OP_STORE) begin
        return {{52{w[31]}}, w[31:25], w[11:7]};
    end else if (op == id_pkg::OP_JALR || op == id_pkg::OP_LOAD || op == id_pkg::OP_IMM ||
                 op == id_pkg::OP_IMM32 || op == id_pkg::OP_SYSTEM) begin
        return {{52{w[31]}}, w[31:20]};
    end
    return '0;
endfunction

function automatic id_pkg::alu_op_e model_alu(input logic [2:0] f3, input logic alt);
    id_pkg::alu_op_e tbl [8];
    tbl = '{id_pkg::ALU_ADD, id_pkg::ALU_SLL, id_pkg::ALU_SLT, id_pkg::ALU_SLTU,
            id_pkg::ALU_XOR, id_pkg::ALU_SRL, id_pkg::ALU_OR, id_pkg::ALU_AND};
    if (alt && f3 == 3'b000) begin
        return id_pkg::ALU_SUB;
    end
    if (alt && f3 == 3'b101) begin
        return id_pkg::ALU_SRA;
    end
    return tbl[f3];
endfunction

function automatic id_pkg::ctrl_t model_ctrl(input id_pkg::inst_t w);
    id_pkg::ctrl_t c;
    logic [6:0]    op;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          ok;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    c = '0;
    c.rd = w[11:7];
    ok = 1'b0;
    if (op == id_pkg::OP_LUI || op == id_pkg::OP_AUIPC) begin
        ok = 1'b1;
        c.rf_we = 1'b1;
        c.src2_sel = id_pkg::SRC2_IMM;
        c.src1_sel = (op == id_pkg::OP_LUI) ? id_pkg::SRC1_ZERO : id_pkg::SRC1_PC;
    end else if (op == id_pkg::OP_JAL || (op == id_pkg::OP_JALR && f3 == 3'b000)) begin
        ok = 1'b1;
        c.rf_we = 1'b1;
        c.src1_sel = id_pkg::SRC1_PC;
        c.src2_sel = id_pkg::SRC2_FOUR;
        c.rf_re1 = (op == id_pkg::OP_JALR);
        c.br_type = (op == id_pkg::OP_JAL) ? id_pkg::BR_JAL : id_pkg::BR_JALR;
    end else if (op == id_pkg::OP_BRANCH && f3[2:1] != 2'b01) begin
        ok = 1'b1;
        c.rf_re1 = 1'b1;
        c.rf_re2 = 1'b1;
        c.alu_op = id_pkg::ALU_SUB;
        c.br_type = (f3 == 3'b000) ? id_pkg::BR_BEQ  :
                    (f3 == 3'b001) ? id_pkg::BR_BNE  :
                    (f3 == 3'b100) ? id_pkg::BR_BLT  :
                    (f3 == 3'b101) ? id_pkg::BR_BGE  :
                    (f3 == 3'b110) ? id_pkg::BR_BLTU : id_pkg::BR_BGEU;
    end else if ((op == id_pkg::OP_LOAD && f3 != 3'b111) ||
                 (op == id_pkg::OP_STORE && !f3[2])) begin
        ok = 1'b1;
        c.rf_re1 = 1'b1;
        c.mem_ena = 1'b1;
        c.src2_sel = id_pkg::SRC2_IMM;
        c.mem_size = id_pkg::mem_size_e'(f3[1:0]);
        c.load = (op == id_pkg::OP_LOAD);
        c.rf_we = c.load;
        c.mem_unsigned = c.load && f3[2];
        c.rf_re2 = !c.load;
        c.mem_wen = !c.load;
    end else if (op == id_pkg::OP_IMM || op == id_pkg::OP_IMM32) begin
        c.word_op = (op == id_pkg::OP_IMM32);
        // shift amounts: 6 bits, or 5 in the word forms
        if (f3 == 3'b001) begin
            ok = c.word_op ? (f7 == 7'h00) : (w[31:26] == 6'h00);
        end else if (f3 == 3'b101) begin
            ok = c.word_op ? (f7 == 7'h00 || f7 == 7'h20)
                           : (w[31:26] == 6'h00 || w[31:26] == 6'h10);
        end else begin
            ok = !c.word_op || f3 == 3'b000;
        end
        c.rf_re1 = 1'b1;
        c.rf_we = 1'b1;
        c.src2_sel = id_pkg::SRC2_IMM;
        c.alu_op = model_alu(f3, f3 == 3'b101 && w[30]);
    end else if (op == id_pkg::OP_REG || op == id_pkg::OP_REG32) begin
        c.word_op = (op == id_pkg::OP_REG32);
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        if (c.word_op && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) begin
            ok = 1'b0;
        end
        c.rf_re1 = 1'b1;
        c.rf_re2 = 1'b1;
        c.rf_we = 1'b1;
        c.alu_op = model_alu(f3, f7[5]);
    end else if (w == 32'h0010_0073) begin
        ok = 1'b1;
        c.ebreak = 1'b1;
    end
    if (!ok) begin
        c = '0;
        c.illegal = 1'b1;
    end
    return c;
endfunction

function automatic logic byp_match(input id_pkg::byp_t b, input id_pkg::reg_addr_t idx);
    return b.we && b.waddr == idx && idx != 5'd0;
endfunction

function automatic id_pkg::xlen_t model_operand(
    input id_pkg::reg_addr_t idx,
    input id_pkg::byp_t      ex,
    input id_pkg::byp_t      mem,
    input id_pkg::byp_t      wb,
    input id_pkg::xlen_t     rf_val
);
    id_pkg::xlen_t v;
    v = (idx == 5'd0) ? '0 : rf_val;
    if (byp_match(wb, idx)) v = wb.data;
    if (byp_match(mem, idx) && !mem.load) v = mem.data;
    if (byp_match(ex, idx) && !ex.load) v = ex.data;
    return v;
endfunction

function automatic logic model_stall(
    input id_pkg::reg_addr_t idx,
    input logic              used,
    input id_pkg::byp_t      ex,
    input id_pkg::byp_t      mem
);
    return used && ((byp_match(ex, idx) && ex.load) || (byp_match(mem, idx) && mem.load));
endfunction

function automatic logic model_taken(
    input id_pkg::br_type_e bt,
    input id_pkg::xlen_t    a,
    input id_pkg::xlen_t    b
);
    case (bt)
        id_pkg::BR_JAL, id_pkg::BR_JALR: return 1'b1;
        id_pkg::BR_BEQ:  return a == b;
        id_pkg::BR_BNE:  return a != b;
        id_pkg::BR_BLT:  return $signed(a) < $signed(b);
        id_pkg::BR_BGE:  return $signed(a) >= $signed(b);
        id_pkg::BR_BLTU: return a < b;
        id_pkg::BR_BGEU: return a >= b;
        default:         return 1'b0;
    endcase
endfunction

`endif

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_CYCLES = 3000;

    logic              clk;
    logic              arst_n;
    id_pkg::xlen_t     pc;
    id_pkg::inst_t     inst;
    id_pkg::byp_t      ex_byp;
    id_pkg::byp_t      mem_byp;
    id_pkg::byp_t      wb_byp;
    id_pkg::ctrl_t     ctrl;
    id_pkg::xlen_t     alu_src1;
    id_pkg::xlen_t     alu_src2;
    id_pkg::xlen_t     store_data;
    logic              branch;
    id_pkg::xlen_t     branch_pc;
    logic              stall;
    id_pkg::xlen_t     shadow [32];
    int                ctrl_errs;
    int                word_errs;
    int                flag_errs;

    `include "id_tb_model.svh"

    id_stage DUT (
        .clk          (clk       ),
        .arst_n_i     (arst_n    ),
        .pc_i         (pc        ),
        .inst_i       (inst      ),
        .ex_byp_i     (ex_byp    ),
        .mem_byp_i    (mem_byp   ),
        .wb_byp_i     (wb_byp    ),
        .ctrl_o       (ctrl      ),
        .alu_src1_o   (alu_src1  ),
        .alu_src2_o   (alu_src2  ),
        .store_data_o (store_data),
        .branch_o     (branch    ),
        .branch_pc_o  (branch_pc ),
        .stall_o      (stall     )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_ctrl(input id_pkg::ctrl_t exp, input id_pkg::ctrl_t got);
        if (got !== exp) begin
            $display("[FAIL] %0t ctrl for inst %h: exp %h got %h", $time, inst, exp, got);
            ctrl_errs++;
        end
    endtask

    task automatic check_word(input string name, input id_pkg::xlen_t exp,
                              input id_pkg::xlen_t got);
        if (got !== exp) begin
            $display("[FAIL] %0t %s for inst %h: exp %h got %h", $time, name, inst, exp, got);
            word_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("[FAIL] %0t %s for inst %h: exp %b got %b", $time, name, inst, exp, got);
            flag_errs++;
        end
    endtask

    // returns at the next rising clock edge
    task automatic next_edge();
        bit seen;
        seen = 0;
        fork
            begin
                @(posedge clk);
                seen = 1;
            end
            #(CLK_PERIOD * 4);
        join_any
        disable fork;
        if (!seen) begin
            $display("timeout: the clock stopped, no rising edge within four periods");
            $display("TB FAILED");
            $finish;
        end
    endtask

    function automatic id_pkg::byp_t rand_byp();
        id_pkg::byp_t b;
        b.we = $urandom_range(0, 3) != 0;
        b.load = $urandom_range(0, 3) == 0;
        b.waddr = 5'($urandom_range(0, 7));
        b.data = {$urandom, $urandom};
        return b;
    endfunction

    function automatic id_pkg::inst_t gen_inst();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  top;
        int          pick;
        r = $urandom;
        rd = 5'($urandom_range(0, 7));
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        f3 = 3'($urandom_range(0, 7));
        // mostly legal upper bits for shifts and reg ops
        top = ($urandom_range(0, 3) == 0) ? r[31:25] : {1'b0, r[30], 5'b0};
        pick = $urandom_range(0, 99);
        if (pick < 6) return {r[31:12], rd, id_pkg::OP_LUI};
        if (pick < 12) return {r[31:12], rd, id_pkg::OP_AUIPC};
        if (pick < 18) return {r[31:12], rd, id_pkg::OP_JAL};
        if (pick < 26) return {r[31:20], rs1, 3'b000, rd, id_pkg::OP_JALR};
        if (pick < 40) return {r[31:25], rs2, rs1, f3, r[11:7], id_pkg::OP_BRANCH};
        if (pick < 48) return {r[31:20], rs1, f3, rd, id_pkg::OP_LOAD};
        if (pick < 55) return {r[31:25], rs2, rs1, f3, r[11:7], id_pkg::OP_STORE};
        if (pick < 66) return {top, r[24:20], rs1, f3, rd, id_pkg::OP_IMM};
        if (pick < 72) return {top, r[24:20], rs1, f3, rd, id_pkg::OP_IMM32};
        if (pick < 83) return {top, rs2, rs1, f3, rd, id_pkg::OP_REG};
        if (pick < 90) return {top, rs2, rs1, f3, rd, id_pkg::OP_REG32};
        if (pick < 94) return 32'h0010_0073;
        return r;
    endfunction

    task automatic check_outputs();
        id_pkg::ctrl_t ec;
        id_pkg::xlen_t imm;
        id_pkg::xlen_t op1;
        id_pkg::xlen_t op2;
        id_pkg::xlen_t s1;
        id_pkg::xlen_t s2;
        id_pkg::xlen_t tgt;
        logic          taken;
        logic          stl;
        ec = model_ctrl(inst);
        imm = model_imm(inst);
        op1 = model_operand(inst[19:15], ex_byp, mem_byp, wb_byp, shadow[inst[19:15]]);
        op2 = model_operand(inst[24:20], ex_byp, mem_byp, wb_byp, shadow[inst[24:20]]);
        s1 = (ec.src1_sel == id_pkg::SRC1_PC) ? pc :
             (ec.src1_sel == id_pkg::SRC1_ZERO) ? 64'd0 : op1;
        s2 = (ec.src2_sel == id_pkg::SRC2_IMM) ? imm :
             (ec.src2_sel == id_pkg::SRC2_FOUR) ? 64'd4 : op2;
        taken = model_taken(ec.br_type, op1, op2);
        tgt = '0;
        if (taken && ec.br_type == id_pkg::BR_JALR) begin
            tgt = (op1 + imm) & ~64'd1;
        end else if (taken) begin
            tgt = pc + imm;
        end
        stl = model_stall(inst[19:15], ec.rf_re1, ex_byp, mem_byp) ||
              model_stall(inst[24:20], ec.rf_re2, ex_byp, mem_byp);
        check_ctrl(ec, ctrl);
        check_word("alu_src1", s1, alu_src1);
        check_word("alu_src2", s2, alu_src2);
        check_word("store_data", op2, store_data);
        check_word("branch_pc", tgt, branch_pc);
        check_flag("branch", taken, branch);
        check_flag("stall", stl, stall);
    endtask

    initial begin
        #(CLK_PERIOD * (NUM_CYCLES + 200));
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk = 0;
        arst_n = 0;
        pc = '0;
        inst = '0;
        ex_byp = '0;
        mem_byp = '0;
        wb_byp = '0;
        ctrl_errs = 0;
        word_errs = 0;
        flag_errs = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        void'($urandom(32'h812f_9a24));
        repeat (3) next_edge();
        #1 arst_n = 1;
        // every register reads zero after reset
        // opcode 0 keeps the word illegal
        for (int i = 0; i < 32; i++) begin
            inst = {7'b0, 5'(i), 5'(i), 3'b0, 5'b0, 7'b0};
            #2 check_outputs();
            next_edge();
            #1;
        end
        for (int n = 0; n < NUM_CYCLES; n++) begin
            inst = gen_inst();
            pc = {$urandom, $urandom};
            ex_byp = rand_byp();
            mem_byp = rand_byp();
            wb_byp = rand_byp();
            #2 check_outputs();
            next_edge();
            if (wb_byp.we && wb_byp.waddr != 5'd0) begin
                shadow[wb_byp.waddr] = wb_byp.data;
            end
            #1;
        end
        $display("errors: ctrl %0d, word %0d, flag %0d", ctrl_errs, word_errs, flag_errs);
        if (ctrl_errs + word_errs + flag_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
id_pkg.sv
id_regfile.sv
id_operand_fetch.sv
id_decoder.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module tb_id_stage -o sim_id \
    && ./obj_dir/sim_id > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
